// ==== Bender.yml ====
package:
  name: arith_unit

sources:
  - hdl/arithPkg.sv
  - hdl/operandIf.sv
  - hdl/operandControl.sv
  - hdl/addSubUnit.sv
  - hdl/shiftAddMultiplier.sv
  - hdl/resultCombiner.sv
  - hdl/arithUnitTop.sv
  - target: test
    files:
      - dv/arithUnitProps.sv
      - dv/arithUnitTb.sv

// ==== dv/arithUnitProps.sv ====
`timescale 1ns/100ps

module arithUnitProps (
  input logic           CLK,
  input logic           RST,
  input logic           cmdValid,
  input logic           cmdReady,
  input logic           rspValid,
  input logic           rspReady,
  input arithPkg::dataT rspData,
  input logic           rspOverflow,
  input logic           rspNegative
);

  int assertFails = 0;
  logic pending;

  // Set by an accepted command, cleared by its response
  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      pending <= 1'b0;
    end
    else if (cmdValid && cmdReady)
    begin
      pending <= 1'b1;
    end
    else if (rspValid && rspReady)
    begin
      pending <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Handshake properties

  readyValidExclusive: assert property (
    @(posedge CLK) disable iff (RST) !(cmdReady && rspValid))
  else
  begin
    assertFails++;
    $error("cmdReady and rspValid are high together");
  end

  rspHeld: assert property (
    @(posedge CLK) disable iff (RST)
    (rspValid && !rspReady) |=> (rspValid && $stable(rspData) &&
                                 $stable(rspOverflow) && $stable(rspNegative)))
  else
  begin
    assertFails++;
    $error("Response changed before rspReady");
  end

  rspNeedsCommand: assert property (
    @(posedge CLK) disable iff (RST) (rspValid && rspReady) |-> pending)
  else
  begin
    assertFails++;
    $error("Response without an accepted command");
  end

  oneInFlight: assert property (
    @(posedge CLK) disable iff (RST) (cmdValid && cmdReady) |-> !pending)
  else
  begin
    assertFails++;
    $error("Command accepted before the previous response");
  end

endmodule

bind arithUnitTop arithUnitProps props0 (.*);

// ==== dv/arithUnitTb.sv ====
`timescale 1ns/100ps

module arithUnitTb;

  localparam int ResetCycles = 5;
  localparam int NumDirected = 9;
  localparam int NumRandom = 300;
  // Stalled Mul plus idle gap needs roughly 15 cycles
  localparam int TimeoutCycles = (NumDirected + NumRandom) * 20 + ResetCycles;

  logic CLK;
  logic RST;
  logic cmdValid;
  logic cmdReady;
  arithPkg::opT cmdOp;
  arithPkg::dataT cmdData;
  logic cmdSigned;
  logic rspValid;
  logic rspReady;
  arithPkg::dataT rspData;
  logic rspOverflow;
  logic rspNegative;

  logic [15:0] lfsrState;
  arithPkg::dataT modelA;
  arithPkg::dataT modelB;
  int errorCount;
  int checkCount;
  int totalErrors;
  logic [31:0] bits;
  arithPkg::opT randOp;
  arithPkg::dataT randData;
  logic randSigned;

  arithUnitTop #(.DataWidth(arithPkg::DefaultDataWidth)) dut0 (
    .CLK         (CLK),
    .RST         (RST),
    .cmdValid    (cmdValid),
    .cmdReady    (cmdReady),
    .cmdOp       (cmdOp),
    .cmdData     (cmdData),
    .cmdSigned   (cmdSigned),
    .rspValid    (rspValid),
    .rspReady    (rspReady),
    .rspData     (rspData),
    .rspOverflow (rspOverflow),
    .rspNegative (rspNegative)
  );

  always #5 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers

  // Galois LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0])
    begin
      next = next ^ 16'hB400;
    end
    return next;
  endfunction

  // One LFSR step per bit taken
  task automatic drawBits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  task automatic stepCycle();
    @(posedge CLK);
    #1;
  endtask

  function automatic string opLabel(input arithPkg::opT op);
    case (op)
      arithPkg::opLoadA: return "LoadA";
      arithPkg::opLoadB: return "LoadB";
      arithPkg::opAdd:   return "Add";
      arithPkg::opSub:   return "Sub";
      default:           return "Mul";
    endcase
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checkCount++;
    assert (expected === actual)
    else
    begin
      errorCount++;
      $display("[FAIL] %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Reference model

  task automatic predict(input arithPkg::opT op, input arithPkg::dataT data,
                         input logic signedMode, output arithPkg::dataT result,
                         output logic ovf, output logic neg);
    int sa;
    int sb;
    int full;
    result = data;
    ovf = 1'b0;
    if (op == arithPkg::opLoadA)
    begin
      modelA = data;
    end
    else if (op == arithPkg::opAdd || op == arithPkg::opSub)
    begin
      // Range of the signed or unsigned view decides overflow
      if (signedMode)
      begin
        sa = $signed(modelA);
        sb = $signed(modelB);
      end
      else
      begin
        sa = modelA;
        sb = modelB;
      end
      full = (op == arithPkg::opAdd) ? sb + sa : sb - sa;
      result = full[15:0];
      if (signedMode)
      begin
        ovf = (full > 32767) || (full < -32768);
      end
      else
      begin
        ovf = (full > 65535) || (full < 0);
      end
    end
    else if (op == arithPkg::opMul)
    begin
      if (signedMode)
      begin
        sa = $signed(modelA[7:0]);
        sb = $signed(modelB[7:0]);
      end
      else
      begin
        sa = modelA[7:0];
        sb = modelB[7:0];
      end
      full = sa * sb;
      result = full[15:0];
    end
    // Every op but LoadA leaves its result in B
    if (op != arithPkg::opLoadA)
    begin
      modelB = result;
    end
    neg = signedMode & result[15];
  endtask

  ////////////////////////////////////////
  // One command from request to response

  task automatic runCommand(input arithPkg::opT op, input arithPkg::dataT data,
                            input logic signedMode);
    arithPkg::dataT expData;
    arithPkg::dataT heldData;
    logic expOvf;
    logic expNeg;
    logic heldOvf;
    logic heldNeg;
    logic accepted;
    logic done;
    logic holding;
    logic [31:0] stall;
    string label;
    label = opLabel(op);
    predict(op, data, signedMode, expData, expOvf, expNeg);
    cmdValid = 1'b1;
    cmdOp = op;
    cmdData = data;
    cmdSigned = signedMode;
    accepted = 1'b0;
    while (!accepted)
    begin
      checkValue("rspValid before accept", 0, rspValid);
      accepted = cmdReady;
      stepCycle();
    end
    cmdValid = 1'b0;
    done = 1'b0;
    holding = 1'b0;
    while (!done)
    begin
      // Ready low about one cycle in four
      drawBits(2, stall);
      rspReady = stall[1:0] != 2'b00;
      checkValue("cmdReady while busy", 0, cmdReady);
      if (holding)
      begin
        checkValue($sformatf("%s held rspValid", label), 1, rspValid);
        checkValue($sformatf("%s held rspData", label), heldData, rspData);
        checkValue($sformatf("%s held rspOverflow", label), heldOvf, rspOverflow);
        checkValue($sformatf("%s held rspNegative", label), heldNeg, rspNegative);
      end
      if (rspValid && rspReady)
      begin
        checkValue($sformatf("%s rspData", label), expData, rspData);
        checkValue($sformatf("%s rspOverflow", label), expOvf, rspOverflow);
        checkValue($sformatf("%s rspNegative", label), expNeg, rspNegative);
        done = 1'b1;
      end
      else if (rspValid)
      begin
        holding = 1'b1;
        heldData = rspData;
        heldOvf = rspOverflow;
        heldNeg = rspNegative;
      end
      stepCycle();
    end
    rspReady = 1'b0;
    // Exactly one response and then ready for the next command
    checkValue("rspValid after handshake", 0, rspValid);
    checkValue("cmdReady after handshake", 1, cmdReady);
  endtask

  ////////////////////////////////////////
  // Main sequence

  initial
  begin
    CLK = 1'b0;
    RST = 1'b1;
    cmdValid = 1'b0;
    cmdOp = arithPkg::opLoadA;
    cmdData = '0;
    cmdSigned = 1'b0;
    rspReady = 1'b0;
    lfsrState = 16'd63;
    modelA = '0;
    modelB = '0;
    errorCount = 0;
    checkCount = 0;
    repeat (ResetCycles) @(posedge CLK);
    #1;
    RST = 1'b0;
    checkValue("reset cmdReady", 1, cmdReady);
    checkValue("reset rspValid", 0, rspValid);

    // Directed loads, overflow corners and a chain without reloads
    runCommand(arithPkg::opLoadA, 16'h1234, 1'b0);
    runCommand(arithPkg::opLoadB, 16'h8001, 1'b0);
    runCommand(arithPkg::opLoadA, 16'h7FFF, 1'b0);
    runCommand(arithPkg::opLoadB, 16'h0001, 1'b0);
    runCommand(arithPkg::opAdd, 16'h0000, 1'b1);
    runCommand(arithPkg::opSub, 16'h0000, 1'b0);
    runCommand(arithPkg::opSub, 16'h0000, 1'b0);
    runCommand(arithPkg::opMul, 16'h0000, 1'b1);
    runCommand(arithPkg::opAdd, 16'h0000, 1'b0);

    for (int n = 0; n < NumRandom; n++)
    begin
      drawBits(3, bits);
      case (bits[2:1])
        2'd0: randOp = bits[0] ? arithPkg::opLoadB : arithPkg::opLoadA;
        2'd1: randOp = arithPkg::opAdd;
        2'd2: randOp = arithPkg::opSub;
        default: randOp = arithPkg::opMul;
      endcase
      drawBits(16, bits);
      randData = bits[15:0];
      drawBits(1, bits);
      randSigned = bits[0];
      runCommand(randOp, randData, randSigned);
      drawBits(2, bits);
      repeat (bits[1:0]) stepCycle();
    end

    totalErrors = errorCount + dut0.props0.assertFails;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d",
             checkCount, errorCount, dut0.props0.assertFails);
    if (totalErrors == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    repeat (TimeoutCycles) @(posedge CLK);
    $display("Timeout after %0d cycles, the DUT stopped answering", TimeoutCycles);
    $display("Simulation failed");
    $finish;
  end

endmodule

// ==== flist.f ====
hdl/arithPkg.sv
hdl/operandIf.sv
hdl/operandControl.sv
hdl/addSubUnit.sv
hdl/shiftAddMultiplier.sv
hdl/resultCombiner.sv
hdl/arithUnitTop.sv
dv/arithUnitProps.sv
dv/arithUnitTb.sv

// ==== hdl/addSubUnit.sv ====
`timescale 1ns/100ps

module addSubUnit #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
) (
  input  logic           CLK,
  input  logic           RST,
  operandIf.unit         opBus,
  output logic           addDone,
  output arithPkg::dataT addResult,
  output logic           addOverflow
);

  logic isSub;
  logic start;
  logic [DataWidth-1:0] addend;
  logic [DataWidth:0] sum;
  logic carryOut;
  logic unsignedOvf;
  logic signedOvf;

  assign isSub = opBus.op == arithPkg::opSub;
  assign start = opBus.issue & (isSub | (opBus.op == arithPkg::opAdd));

  // One adder for both, subtract is B + ~A + 1
  assign addend = isSub ? ~opBus.opA : opBus.opA;
  assign sum = {1'b0, opBus.opB} + {1'b0, addend} + (DataWidth + 1)'(isSub);
  assign carryOut = sum[DataWidth];

  // Borrow is the missing carry
  assign unsignedOvf = isSub ? ~carryOut : carryOut;
  // Same input signs but a different result sign
  assign signedOvf = (opBus.opB[DataWidth-1] == addend[DataWidth-1]) &&
                     (sum[DataWidth-1] != opBus.opB[DataWidth-1]);

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      addDone <= 1'b0;
    end
    else
    begin
      addDone <= start;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (start)
    begin
      addResult   <= sum[DataWidth-1:0];
      addOverflow <= opBus.signedMode ? signedOvf : unsignedOvf;
    end
  end

endmodule

// ==== hdl/arithPkg.sv ====
package arithPkg;

  ////////////////////////////////////////
  // Widths

  // Operand width unless the top level overrides it
  localparam int DefaultDataWidth = 16;

  // Operand or result word
  typedef logic [DefaultDataWidth-1:0] dataT;

  // One multiplier operand, the low half of a word
  typedef logic [DefaultDataWidth/2-1:0] halfT;

  ////////////////////////////////////////
  // Encodings

  // Command opcodes
  typedef enum logic [2:0] {
    opLoadA = 3'd0,
    opLoadB = 3'd1,
    opAdd   = 3'd2,
    opSub   = 3'd3,
    opMul   = 3'd4
  } opT;

  // Shift-and-add multiplier FSM
  typedef enum logic [1:0] {
    mulIdle = 2'd0,
    mulRun  = 2'd1,
    mulDone = 2'd2
  } mulStateT;

endpackage

// ==== hdl/arithUnitTop.sv ====
`timescale 1ns/100ps

module arithUnitTop #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           cmdValid,
  output logic           cmdReady,
  input  arithPkg::opT   cmdOp,
  input  arithPkg::dataT cmdData,
  input  logic           cmdSigned,
  output logic           rspValid,
  input  logic           rspReady,
  output arithPkg::dataT rspData,
  output logic           rspOverflow,
  output logic           rspNegative
);

  logic addDone;
  arithPkg::dataT addResult;
  logic addOverflow;
  logic mulDone;
  arithPkg::dataT mulResult;
  logic wbValid;
  arithPkg::dataT wbData;

  operandIf #(.DataWidth(DataWidth)) opBus ();

  ////////////////////////////////////////
  // Command side

  operandControl #(.DataWidth(DataWidth)) control0 (
    .CLK       (CLK),
    .RST       (RST),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .cmdSigned (cmdSigned),
    .wbValid   (wbValid),
    .wbData    (wbData),
    .opBus     (opBus)
  );

  ////////////////////////////////////////
  // Arithmetic units side by side

  addSubUnit #(.DataWidth(DataWidth)) addSub0 (
    .CLK         (CLK),
    .RST         (RST),
    .opBus       (opBus),
    .addDone     (addDone),
    .addResult   (addResult),
    .addOverflow (addOverflow)
  );

  shiftAddMultiplier #(.DataWidth(DataWidth)) mul0 (
    .CLK       (CLK),
    .RST       (RST),
    .opBus     (opBus),
    .mulDone   (mulDone),
    .mulResult (mulResult)
  );

  ////////////////////////////////////////
  // Response side

  resultCombiner #(.DataWidth(DataWidth)) combiner0 (
    .CLK         (CLK),
    .RST         (RST),
    .rspReady    (rspReady),
    .addDone     (addDone),
    .addResult   (addResult),
    .addOverflow (addOverflow),
    .mulDone     (mulDone),
    .mulResult   (mulResult),
    .opBus       (opBus),
    .rspValid    (rspValid),
    .rspData     (rspData),
    .rspOverflow (rspOverflow),
    .rspNegative (rspNegative),
    .wbValid     (wbValid),
    .wbData      (wbData)
  );

endmodule

// ==== hdl/operandControl.sv ====
`timescale 1ns/100ps

module operandControl #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           cmdValid,
  output logic           cmdReady,
  input  arithPkg::opT   cmdOp,
  input  arithPkg::dataT cmdData,
  input  logic           cmdSigned,
  input  logic           wbValid,
  input  arithPkg::dataT wbData,
  operandIf.master       opBus
);

  logic busy;
  logic cmdAccept;
  logic issueQ;
  arithPkg::opT opQ;
  logic signedQ;
  logic [DataWidth-1:0] regA;
  logic [DataWidth-1:0] regB;

  // Only one command in flight, the next one needs the new B
  assign cmdReady = ~busy;
  assign cmdAccept = cmdValid & ~busy;

  ////////////////////////////////////////
  // Command capture and operand registers

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      busy    <= 1'b0;
      issueQ  <= 1'b0;
      opQ     <= arithPkg::opLoadA;
      signedQ <= 1'b0;
      regA    <= '0;
      regB    <= '0;
    end
    else
    begin
      issueQ <= cmdAccept;
      if (cmdAccept)
      begin
        busy    <= 1'b1;
        opQ     <= cmdOp;
        signedQ <= cmdSigned;
        // Loads land here so the issued operands are already updated
        if (cmdOp == arithPkg::opLoadA)
        begin
          regA <= cmdData;
        end
        if (cmdOp == arithPkg::opLoadB)
        begin
          regB <= cmdData;
        end
      end
      else if (wbValid)
      begin
        busy <= 1'b0;
        // LoadA answers with A, B stays as it was
        if (opQ != arithPkg::opLoadA)
        begin
          regB <= wbData;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Issue to the units

  // Held stable until the write-back since nothing changes while busy
  assign opBus.issue      = issueQ;
  assign opBus.op         = opQ;
  assign opBus.opA        = regA;
  assign opBus.opB        = regB;
  assign opBus.signedMode = signedQ;

endmodule

// ==== hdl/operandIf.sv ====
`timescale 1ns/100ps

interface operandIf #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
);

  // One-cycle pulse that starts the issued command
  logic issue;
  arithPkg::opT op;
  // Operands as they stand after any load
  logic [DataWidth-1:0] opA;
  logic [DataWidth-1:0] opB;
  logic signedMode;

  modport master (
    output issue,
    output op,
    output opA,
    output opB,
    output signedMode
  );

  modport unit (
    input issue,
    input op,
    input opA,
    input opB,
    input signedMode
  );

endinterface

// ==== hdl/resultCombiner.sv ====
`timescale 1ns/100ps

module resultCombiner #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
) (
  input  logic           CLK,
  input  logic           RST,
  input  logic           rspReady,
  input  logic           addDone,
  input  arithPkg::dataT addResult,
  input  logic           addOverflow,
  input  logic           mulDone,
  input  arithPkg::dataT mulResult,
  operandIf.unit         opBus,
  output logic           rspValid,
  output arithPkg::dataT rspData,
  output logic           rspOverflow,
  output logic           rspNegative,
  output logic           wbValid,
  output arithPkg::dataT wbData
);

  logic loadIssue;
  logic capture;
  logic [DataWidth-1:0] nextData;

  // Loads have no unit of their own, they answer on issue
  assign loadIssue = opBus.issue &&
                     (opBus.op == arithPkg::opLoadA || opBus.op == arithPkg::opLoadB);
  assign capture = loadIssue | addDone | mulDone;

  always_comb
  begin
    if (addDone)
    begin
      nextData = addResult;
    end
    else if (mulDone)
    begin
      nextData = mulResult;
    end
    else if (opBus.op == arithPkg::opLoadA)
    begin
      nextData = opBus.opA;
    end
    else
    begin
      nextData = opBus.opB;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      rspValid <= 1'b0;
    end
    else if (capture)
    begin
      rspValid <= 1'b1;
    end
    else if (rspValid && rspReady)
    begin
      rspValid <= 1'b0;
    end
  end

  // Response payload holds under back-pressure
  always_ff @(posedge CLK)
  begin
    if (capture)
    begin
      rspData     <= nextData;
      rspOverflow <= addDone & addOverflow;
      rspNegative <= opBus.signedMode & nextData[DataWidth-1];
    end
  end

  // Control decides from its own op whether B takes this
  assign wbValid = rspValid & rspReady;
  assign wbData  = rspData;

endmodule

// ==== hdl/shiftAddMultiplier.sv ====
`timescale 1ns/100ps

module shiftAddMultiplier #(
  parameter int DataWidth = arithPkg::DefaultDataWidth
) (
  input  logic           CLK,
  input  logic           RST,
  operandIf.unit         opBus,
  output logic           mulDone,
  output arithPkg::dataT mulResult
);

  localparam int HalfWidth = DataWidth / 2;
  localparam int StepWidth = (HalfWidth > 1) ? $clog2(HalfWidth) : 1;

  arithPkg::mulStateT state;
  logic [StepWidth-1:0] stepCnt;
  logic startMul;
  logic lastStep;
  logic [DataWidth-1:0] multiplicand;
  logic [DataWidth-1:0] partial;
  logic [DataWidth-1:0] accum;
  arithPkg::halfT multiplier;

  assign startMul = opBus.issue && (opBus.op == arithPkg::opMul);
  assign lastStep = stepCnt == StepWidth'(HalfWidth - 1);

  // Multiplier shifts right so bit 0 is always the current one
  assign partial = multiplier[0] ? multiplicand : '0;

  ////////////////////////////////////////
  // Step FSM

  always_ff @(posedge CLK)
  begin
    if (RST)
    begin
      state   <= arithPkg::mulIdle;
      stepCnt <= '0;
    end
    else
    begin
      case (state)
        arithPkg::mulIdle:
        begin
          stepCnt <= '0;
          if (startMul)
          begin
            state <= arithPkg::mulRun;
          end
        end
        arithPkg::mulRun:
        begin
          stepCnt <= stepCnt + 1'b1;
          if (lastStep)
          begin
            state <= arithPkg::mulDone;
          end
        end
        default:
        begin
          state <= arithPkg::mulIdle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath

  always_ff @(posedge CLK)
  begin
    if (state == arithPkg::mulIdle && startMul)
    begin
      // Sign-extend the multiplicand in signed mode
      multiplicand <= {{HalfWidth{opBus.signedMode & opBus.opA[HalfWidth-1]}},
                       opBus.opA[HalfWidth-1:0]};
      multiplier   <= opBus.opB[HalfWidth-1:0];
      accum        <= '0;
    end
    else if (state == arithPkg::mulRun)
    begin
      // Sign bit of the multiplier weighs negative
      if (lastStep && opBus.signedMode)
      begin
        accum <= accum - partial;
      end
      else
      begin
        accum <= accum + partial;
      end
      multiplicand <= multiplicand << 1;
      multiplier   <= multiplier >> 1;
    end
  end

  assign mulDone   = state == arithPkg::mulDone;
  assign mulResult = accum;

endmodule
